//--- files.f
source/mul_types_pkg.sv
source/mac_ops_pkg.sv
source/partial_product_gen.sv
source/product_reduce.sv
source/mac_accumulator.sv
source/mac_unit_top.sv
test/mac_unit_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the MAC unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module mac_unit_tb \
    -f files.f

./obj_dir/Vmac_unit_tb | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
    echo "Simulation result: pass"
    exit 0
else
    echo "Simulation result: fail"
    exit 1
fi

//--- source/mac_accumulator.sv
// Stage 3: opcode decode, wrapping accumulator, result and overflow registers
`timescale 1ns/1ps

module mac_accumulator #(
    parameter int OPERAND_W = mul_types_pkg::OPERAND_W,
    parameter int ACC_W     = mul_types_pkg::ACC_W
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 s2_valid,
    input  mac_ops_pkg::mac_op_e s2_op,
    input  logic [mul_types_pkg::product_width(OPERAND_W)-1:0] s2_product,
    output logic                 result_valid,
    output logic [ACC_W-1:0]     result,
    output logic                 overflow
);

    import mac_ops_pkg::*;

    logic [ACC_W-1:0] acc_q;
    logic [ACC_W-1:0] acc_next;
    logic [ACC_W-1:0] prod_ext;
    logic [ACC_W:0]   mac_sum;
    logic [ACC_W-1:0] res_next;
    logic             ovf_next;
    logic             has_result;

    assign prod_ext   = ACC_W'(s2_product);
    // Extra top bit catches the carry out of the accumulator
    assign mac_sum    = {1'b0, acc_q} + {1'b0, prod_ext};
    assign has_result = s2_valid && op_has_result(s2_op);

    always_comb begin
        acc_next = acc_q;
        res_next = '0;
        ovf_next = 1'b0;
        if (s2_valid) begin
            case (s2_op)
                OP_MUL: begin
                    res_next = prod_ext;
                end
                OP_MAC: begin
                    acc_next = mac_sum[ACC_W-1:0];
                    res_next = mac_sum[ACC_W-1:0];
                    ovf_next = mac_sum[ACC_W];
                end
                OP_CLEAR: begin
                    acc_next = '0;
                end
                default: begin
                    // No-op leaves everything alone
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q        <= '0;
            result_valid <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            if (s2_valid && op_writes_acc(s2_op)) begin
                acc_q <= acc_next;
            end
            result_valid <= has_result;
            overflow     <= ovf_next;
        end
    end

    always_ff @(posedge clk) begin
        if (has_result) begin
            result <= res_next;
        end
    end

    // A wrap leaves the new sum below the accumulator it started from
    a_overflow_with_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        overflow |-> (result_valid && (result < $past(acc_q)))
    ) else $error("overflow raised without a result strobe or a wrapped sum");

endmodule

//--- source/mac_ops_pkg.sv
// Opcode encoding and opcode helpers for the accumulate control
package mac_ops_pkg;

    typedef enum logic [1:0] {
        OP_NOP   = 2'b00,
        OP_MUL   = 2'b01,
        OP_MAC   = 2'b10,
        OP_CLEAR = 2'b11
    } mac_op_e;

    // Every real operation returns a result
    function automatic bit op_has_result(input mac_op_e op);
        return op != OP_NOP;
    endfunction

    // Opcodes that change the accumulator contents
    function automatic bit op_writes_acc(input mac_op_e op);
        return (op == OP_MAC) || (op == OP_CLEAR);
    endfunction

endpackage

//--- source/mac_unit_top.sv
// Pipelined multiply-accumulate unit, three registered stages
`timescale 1ns/1ps

module mac_unit_top #(
    parameter int OPERAND_W = mul_types_pkg::OPERAND_W,
    parameter int ACC_W     = mul_types_pkg::ACC_W
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  mac_ops_pkg::mac_op_e op,
    input  logic [OPERAND_W-1:0] a,
    input  logic [OPERAND_W-1:0] b,
    output logic                 result_valid,
    output logic [ACC_W-1:0]     result,
    output logic                 overflow
);

    import mul_types_pkg::*;
    import mac_ops_pkg::*;

    localparam int PROD_W = product_width(OPERAND_W);

    logic                              s1_valid;
    mac_op_e                           s1_op;
    logic [OPERAND_W/2-1:0][PROD_W-1:0] s1_rows;

    logic                              s2_valid;
    mac_op_e                           s2_op;
    logic [PROD_W-1:0]                 s2_product;

    partial_product_gen #(
        .OPERAND_W (OPERAND_W)
    ) u_partial_product_gen (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .op       (op),
        .a        (a),
        .b        (b),
        .s1_valid (s1_valid),
        .s1_op    (s1_op),
        .s1_rows  (s1_rows)
    );

    product_reduce #(
        .OPERAND_W (OPERAND_W)
    ) u_product_reduce (
        .clk        (clk),
        .arst_n     (arst_n),
        .s1_valid   (s1_valid),
        .s1_op      (s1_op),
        .s1_rows    (s1_rows),
        .s2_valid   (s2_valid),
        .s2_op      (s2_op),
        .s2_product (s2_product)
    );

    mac_accumulator #(
        .OPERAND_W (OPERAND_W),
        .ACC_W     (ACC_W)
    ) u_mac_accumulator (
        .clk          (clk),
        .arst_n       (arst_n),
        .s2_valid     (s2_valid),
        .s2_op        (s2_op),
        .s2_product   (s2_product),
        .result_valid (result_valid),
        .result       (result),
        .overflow     (overflow)
    );

endmodule

//--- source/mul_types_pkg.sv
// Width defaults and product sizing for the tree multiplier datapath
package mul_types_pkg;

    // Operand width, power of two and at least 4
    localparam int OPERAND_W = 8;

    // Accumulator width, at least twice the operand width
    localparam int ACC_W = 20;

    // Unsigned product of two operand_w-bit values needs twice the width
    function automatic int product_width(input int operand_w);
        return 2 * operand_w;
    endfunction

endpackage

//--- source/partial_product_gen.sv
// Stage 1: aligned partial products, first pairwise addition, row registers
`timescale 1ns/1ps

module partial_product_gen #(
    parameter int OPERAND_W = mul_types_pkg::OPERAND_W
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 in_valid,
    input  mac_ops_pkg::mac_op_e op,
    input  logic [OPERAND_W-1:0] a,
    input  logic [OPERAND_W-1:0] b,
    output logic                 s1_valid,
    output mac_ops_pkg::mac_op_e s1_op,
    output logic [OPERAND_W/2-1:0][mul_types_pkg::product_width(OPERAND_W)-1:0] s1_rows
);

    import mul_types_pkg::*;
    import mac_ops_pkg::*;

    localparam int PROD_W = product_width(OPERAND_W);
    localparam int ROWS   = OPERAND_W / 2;

    logic [OPERAND_W-1:0][PROD_W-1:0] pp;
    logic [ROWS-1:0][PROD_W-1:0]      rows_next;

    // One partial product per bit of b, moved up to that bit's weight
    always_comb begin
        for (int i = 0; i < OPERAND_W; i++) begin
            pp[i] = b[i] ? (PROD_W'(a) << i) : '0;
        end
    end

    // First adder level, neighbours summed in pairs
    always_comb begin
        for (int k = 0; k < ROWS; k++) begin
            rows_next[k] = pp[2*k] + pp[2*k+1];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s1_op    <= OP_NOP;
        end else begin
            s1_valid <= in_valid;
            // Idle cycles travel as no-ops
            s1_op    <= in_valid ? op : OP_NOP;
        end
    end

    always_ff @(posedge clk) begin
        s1_rows <= rows_next;
    end

    a_s1_valid_known: assert property (
        @(posedge clk) disable iff (!arst_n) !$isunknown(s1_valid)
    ) else $error("s1_valid is unknown after reset");

endmodule

//--- source/product_reduce.sv
// Stage 2: adder tree that folds the stage 1 rows into one product
`timescale 1ns/1ps

module product_reduce #(
    parameter int OPERAND_W = mul_types_pkg::OPERAND_W
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 s1_valid,
    input  mac_ops_pkg::mac_op_e s1_op,
    input  logic [OPERAND_W/2-1:0][mul_types_pkg::product_width(OPERAND_W)-1:0] s1_rows,
    output logic                 s2_valid,
    output mac_ops_pkg::mac_op_e s2_op,
    output logic [mul_types_pkg::product_width(OPERAND_W)-1:0] s2_product
);

    import mul_types_pkg::*;
    import mac_ops_pkg::*;

    localparam int PROD_W = product_width(OPERAND_W);
    localparam int ROWS   = OPERAND_W / 2;
    localparam int LEVELS = $clog2(ROWS);

    // Largest product of two full-scale operands
    localparam logic [PROD_W-1:0] MAX_OPERAND = PROD_W'({OPERAND_W{1'b1}});
    localparam logic [PROD_W-1:0] MAX_PRODUCT = MAX_OPERAND * MAX_OPERAND;

    // Heap-ordered tree, root at 0 and the rows as leaves
    logic [PROD_W-1:0] node [2*ROWS-1];

    genvar lvl, n;
    generate
        for (n = 0; n < ROWS; n++) begin : g_leaf
            assign node[ROWS-1+n] = s1_rows[n];
        end
        for (lvl = 0; lvl < LEVELS; lvl++) begin : g_level
            for (n = 0; n < (1 << lvl); n++) begin : g_node
                localparam int IDX = (1 << lvl) - 1 + n;
                assign node[IDX] = node[2*IDX+1] + node[2*IDX+2];
            end
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
            s2_op    <= OP_NOP;
        end else begin
            s2_valid <= s1_valid;
            s2_op    <= s1_op;
        end
    end

    always_ff @(posedge clk) begin
        s2_product <= node[0];
    end

    // Tree output stays in range for any operand pair from stage 1
    a_product_in_range: assert property (
        @(posedge clk) disable iff (!arst_n) s2_valid |-> (s2_product <= MAX_PRODUCT)
    ) else $error("product above the largest operand product");

endmodule

//--- test/mac_unit_tb.sv
// Testbench for the pipelined MAC unit: seeded random stimulus, queue model,
// compare tasks and a closing report
`timescale 1ns/1ps

module mac_unit_tb;

    import mul_types_pkg::*;
    import mac_ops_pkg::*;

    localparam int OPERAND_W      = mul_types_pkg::OPERAND_W;
    localparam int ACC_W          = mul_types_pkg::ACC_W;
    localparam int PROD_W         = product_width(OPERAND_W);
    localparam int NUM_OPS        = 1500;
    localparam int DIRECTED_OPS   = 64;
    localparam int TIMEOUT_CYCLES = 2 * NUM_OPS + 100;
    // Edges from the drive edge to the edge that registers the result
    localparam int LATENCY        = 3;
    localparam logic [OPERAND_W-1:0] MAX_OP = '1;

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    mac_op_e              op;
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
    logic                 result_valid;
    logic [ACC_W-1:0]     result;
    logic                 overflow;

    logic [31:0]      lcg_state;
    logic [ACC_W-1:0] model_acc;
    logic [ACC_W-1:0] exp_result_q[$];
    logic             exp_ovf_q[$];
    int               exp_cycle_q[$];
    int               cyc;
    int               result_errs;
    int               ovf_errs;
    int               protocol_errs;

    mac_unit_top #(
        .OPERAND_W (OPERAND_W),
        .ACC_W     (ACC_W)
    ) u_mac_unit_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .op           (op),
        .a            (a),
        .b            (b),
        .result_valid (result_valid),
        .result       (result),
        .overflow     (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_result(input logic [ACC_W-1:0] got, input logic [ACC_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: result 0x%h, expected 0x%h", $time, got, exp);
            result_errs++;
        end
    endtask

    task automatic check_overflow(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: overflow %b, expected %b", $time, got, exp);
            ovf_errs++;
        end
    endtask

    // Model runs at issue time, valid since results leave in order
    task automatic issue_op(input mac_op_e op_in, input logic [OPERAND_W-1:0] a_in,
                            input logic [OPERAND_W-1:0] b_in);
        logic [PROD_W-1:0] prod;
        logic [ACC_W:0]    sum;
        logic [ACC_W-1:0]  exp_res;
        logic              exp_ovf;
        @(posedge clk);
        #1;
        in_valid = 1'b1;
        op       = op_in;
        a        = a_in;
        b        = b_in;
        prod     = PROD_W'(a_in) * PROD_W'(b_in);
        sum      = (ACC_W+1)'(model_acc) + (ACC_W+1)'(prod);
        exp_res  = '0;
        exp_ovf  = 1'b0;
        case (op_in)
            OP_MUL: exp_res = ACC_W'(prod);
            OP_MAC: begin
                model_acc = sum[ACC_W-1:0];
                exp_res   = sum[ACC_W-1:0];
                exp_ovf   = sum[ACC_W];
            end
            OP_CLEAR: model_acc = '0;
            default: exp_res = '0;
        endcase
        if (op_has_result(op_in)) begin
            exp_result_q.push_back(exp_res);
            exp_ovf_q.push_back(exp_ovf);
            exp_cycle_q.push_back(cyc + LATENCY);
        end
    endtask

    // Idle cycle with junk on op and operands
    task automatic drive_idle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r        = next_rand();
        in_valid = 1'b0;
        op       = mac_op_e'(r[9:8]);
        a        = r[23:16];
        b        = r[31:24];
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Outputs are sampled mid-cycle, well away from both edges
    always @(negedge clk) begin
        if (!arst_n) begin
            if (result_valid !== 1'b0 || overflow !== 1'b0) begin
                $display("Result strobe or overflow was not low during reset at %0t ns", $time);
                protocol_errs++;
            end
        end else if (result_valid === 1'b1) begin
            if (exp_result_q.size() == 0) begin
                $display("Unexpected result strobe at %0t ns with no operation pending", $time);
                protocol_errs++;
            end else begin
                if (exp_cycle_q[0] != cyc) begin
                    $display("Result at cycle %0d came when cycle %0d was expected",
                             cyc, exp_cycle_q[0]);
                    protocol_errs++;
                end
                check_result(result, exp_result_q.pop_front());
                check_overflow(overflow, exp_ovf_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end else begin
            if (overflow !== 1'b0) begin
                $display("Overflow was high without a result strobe at %0t ns", $time);
                protocol_errs++;
            end
            if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cyc) begin
                $display("Missing result strobe at cycle %0d", cyc);
                protocol_errs++;
                void'(exp_result_q.pop_front());
                void'(exp_ovf_q.pop_front());
                void'(exp_cycle_q.pop_front());
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        mac_op_e     rop;
        arst_n        = 1'b0;
        in_valid      = 1'b0;
        op            = OP_NOP;
        a             = '0;
        b             = '0;
        lcg_state     = 32'h429f;
        model_acc     = '0;
        cyc           = 0;
        result_errs   = 0;
        ovf_errs      = 0;
        protocol_errs = 0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // First accumulate after reset must start from zero
        issue_op(OP_MAC, 8'd3, 8'd4);
        issue_op(OP_MUL, 8'd0, 8'd0);
        issue_op(OP_MUL, 8'd0, MAX_OP);
        issue_op(OP_MUL, 8'd1, MAX_OP);
        issue_op(OP_MUL, MAX_OP, 8'd1);
        issue_op(OP_MUL, 8'd1, 8'd1);
        issue_op(OP_MUL, MAX_OP, MAX_OP);
        issue_op(OP_NOP, MAX_OP, MAX_OP);
        drive_idle();

        // Long full-scale run wraps the accumulator twice
        issue_op(OP_CLEAR, 8'd0, 8'd0);
        repeat (40) issue_op(OP_MAC, MAX_OP, MAX_OP);
        issue_op(OP_CLEAR, 8'd7, 8'd9);
        issue_op(OP_MAC, 8'd2, 8'd5);

        for (int i = 0; i < NUM_OPS - DIRECTED_OPS; i++) begin
            r = next_rand();
            s = next_rand();
            case (s[31:29])
                3'd0: rop = OP_NOP;
                3'd1, 3'd2: rop = OP_MUL;
                3'd7: rop = OP_CLEAR;
                default: rop = OP_MAC;
            endcase
            if (r[26:24] == 3'd0) begin
                r[15:8] = MAX_OP;
            end
            if (r[29:27] == 3'd0) begin
                r[23:16] = MAX_OP;
            end
            issue_op(rop, r[15:8], r[23:16]);
            if (s[3:2] == 2'd0) begin
                drive_idle();
            end
        end

        repeat (LATENCY + 3) drive_idle();
        if (exp_result_q.size() != 0) begin
            $display("%0d expected results never appeared", exp_result_q.size());
            protocol_errs++;
        end
        $display("Summary: result errors %0d, overflow errors %0d, protocol errors %0d",
                 result_errs, ovf_errs, protocol_errs);
        if (result_errs + ovf_errs + protocol_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
